/* src/lc3b_pkg.sv */
package lc3b_pkg;

    // one machine word: data, address or instruction
    typedef logic [15:0] lc3b_word;

    // register index
    typedef logic [2:0] lc3b_reg;

    // byte-lane write enable, bit 0 is the low byte
    typedef logic [1:0] lc3b_mem_wmask;

    // condition code as n, z, p
    typedef logic [2:0] lc3b_nzp;

    // instruction opcodes in LC-3b encoding
    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_ldb = 4'b0010,
        op_stb = 4'b0011,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } lc3b_opcode;

    // ALU functions
    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } lc3b_aluop;

endpackage : lc3b_pkg

/* src/fetch_stage.sv */
module fetch_stage
    import lc3b_pkg::*;
#(
    parameter lc3b_word RESET_PC = 16'h0000
)
(
    input  logic     clk,
    input  logic     rst,
    input  logic     stall,
    input  logic     load_stall,
    input  logic     flush,
    input  lc3b_word branch_target,
    output logic     imem_read,
    output lc3b_word imem_address,
    input  logic     imem_resp,
    input  lc3b_word imem_rdata,
    output logic     fetch_busy,
    output lc3b_word ir_id,
    output lc3b_word pc_id
);

    lc3b_word pc;
    lc3b_word ir_buf;
    logic     have_ir;
    lc3b_word fetched;

    // request runs until the word is either consumed or parked in ir_buf
    assign imem_read    = ~have_ir;
    assign imem_address = pc;
    assign fetch_busy   = ~have_ir & ~imem_resp;
    assign fetched      = have_ir ? ir_buf : imem_rdata;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc      <= RESET_PC;
            have_ir <= 1'b0;
            ir_id   <= '0;
        end
        else if (!stall && flush)
        begin
            // redirect and drop whatever was fetched
            pc      <= branch_target;
            have_ir <= 1'b0;
            ir_id   <= '0;
        end
        else if (!stall && !load_stall)
        begin
            pc      <= pc + 16'd2;
            have_ir <= 1'b0;
            ir_id   <= fetched;
        end
        else if (imem_resp)
        begin
            // pipeline frozen, keep the word until it can move on
            have_ir <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (imem_resp)
        begin
            ir_buf <= imem_rdata;
        end
        if (!stall && !load_stall)
        begin
            pc_id <= pc + 16'd2;
        end
    end

endmodule : fetch_stage

/* src/regfile.sv */
module regfile
    import lc3b_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     load,
    input  lc3b_reg  dest,
    input  lc3b_reg  src_a,
    input  lc3b_reg  src_b,
    input  lc3b_word in,
    output lc3b_word reg_a,
    output lc3b_word reg_b
);

    lc3b_word regs [8];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 8; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (load)
        begin
            regs[dest] <= in;
        end
    end

    // write-through so decode sees the value being written back
    assign reg_a = (load && dest == src_a) ? in : regs[src_a];
    assign reg_b = (load && dest == src_b) ? in : regs[src_b];

endmodule : regfile

/* src/decode_stage.sv */
module decode_stage
    import lc3b_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       stall,
    input  logic       load_stall,
    input  logic       flush,
    input  lc3b_word   ir_id,
    input  lc3b_word   pc_id,
    input  logic       wb_load,
    input  lc3b_reg    wb_dest,
    input  lc3b_word   wb_data,
    output lc3b_reg    sr1_ex,
    output lc3b_reg    sr2_ex,
    output lc3b_word   a_ex,
    output lc3b_word   b_ex,
    output lc3b_word   imm_ex,
    output lc3b_aluop  aluop_ex,
    output lc3b_opcode opcode_ex,
    output lc3b_reg    dest_ex,
    output logic       load_reg_ex,
    output logic       mem_read_ex,
    output logic       mem_write_ex,
    output logic       byte_ex,
    output lc3b_nzp    nzp_ex,
    output lc3b_word   target_ex
);

    lc3b_opcode opcode;
    lc3b_reg    sr1;
    lc3b_reg    sr2;
    lc3b_word   reg_a;
    lc3b_word   reg_b;
    lc3b_word   imm5;
    lc3b_word   off6;
    lc3b_word   off9;
    lc3b_word   imm;
    lc3b_aluop  aluop;
    logic       load_reg;
    logic       mem_read;
    logic       mem_write;
    logic       byte_sel;

    assign opcode = lc3b_opcode'(ir_id[15:12]);
    assign sr1    = ir_id[8:6];
    // stores read their data register from the dest field
    assign sr2    = (opcode == op_str || opcode == op_stb) ? ir_id[11:9] : ir_id[2:0];
    assign imm5   = {{11{ir_id[4]}}, ir_id[4:0]};
    assign off6   = {{10{ir_id[5]}}, ir_id[5:0]};
    assign off9   = {{7{ir_id[8]}}, ir_id[8:0]};

    regfile u_regfile
    (
        .clk   (clk),
        .rst   (rst),
        .load  (wb_load),
        .dest  (wb_dest),
        .src_a (sr1),
        .src_b (sr2),
        .in    (wb_data),
        .reg_a (reg_a),
        .reg_b (reg_b)
    );

    always_comb
    begin
        aluop     = alu_pass;
        imm       = imm5;
        load_reg  = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        byte_sel  = 1'b0;
        case (opcode)
            op_add, op_and:
            begin
                aluop    = (opcode == op_add) ? alu_add : alu_and;
                load_reg = 1'b1;
                // on ALU ops the byte flag marks the imm5 form
                byte_sel = ir_id[5];
            end
            op_not:
            begin
                aluop    = alu_not;
                load_reg = 1'b1;
            end
            op_ldr, op_ldb:
            begin
                aluop    = alu_add;
                imm      = (opcode == op_ldr) ? {off6[14:0], 1'b0} : off6;
                load_reg = 1'b1;
                mem_read = 1'b1;
                byte_sel = (opcode == op_ldb);
            end
            op_str, op_stb:
            begin
                aluop     = alu_add;
                imm       = (opcode == op_str) ? {off6[14:0], 1'b0} : off6;
                mem_write = 1'b1;
                byte_sel  = (opcode == op_stb);
            end
            default:
            begin
                // BR and anything unsupported do nothing here
                aluop = alu_pass;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst || (!stall && flush))
        begin
            opcode_ex    <= op_br;
            nzp_ex       <= '0;
            aluop_ex     <= alu_pass;
            load_reg_ex  <= 1'b0;
            mem_read_ex  <= 1'b0;
            mem_write_ex <= 1'b0;
            byte_ex      <= 1'b0;
        end
        else if (!stall && !load_stall)
        begin
            opcode_ex    <= opcode;
            nzp_ex       <= ir_id[11:9];
            aluop_ex     <= aluop;
            load_reg_ex  <= load_reg;
            mem_read_ex  <= mem_read;
            mem_write_ex <= mem_write;
            byte_ex      <= byte_sel;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall && !load_stall)
        begin
            sr1_ex    <= sr1;
            sr2_ex    <= sr2;
            a_ex      <= reg_a;
            b_ex      <= reg_b;
            imm_ex    <= imm;
            dest_ex   <= ir_id[11:9];
            target_ex <= pc_id + {off9[14:0], 1'b0};
        end
    end

endmodule : decode_stage

/* src/hazard_unit.sv */
module hazard_unit
    import lc3b_pkg::*;
(
    input  lc3b_reg    sr1_ex,
    input  lc3b_reg    sr2_ex,
    input  lc3b_reg    dest_mem,
    input  lc3b_reg    dest_wb,
    input  logic       load_reg_mem,
    input  logic       load_reg_wb,
    input  logic       mem_read_mem,
    output logic [1:0] fwd1_sel,
    output logic [1:0] fwd2_sel,
    output logic       load_stall
);

    logic hit1_mem;
    logic hit2_mem;
    logic hit1_wb;
    logic hit2_wb;

    assign hit1_mem = load_reg_mem && (dest_mem == sr1_ex);
    assign hit2_mem = load_reg_mem && (dest_mem == sr2_ex);
    assign hit1_wb  = load_reg_wb && (dest_wb == sr1_ex);
    assign hit2_wb  = load_reg_wb && (dest_wb == sr2_ex);

    // 01 from memory, 10 from writeback, 00 register file value
    always_comb
    begin
        fwd1_sel = 2'b00;
        fwd2_sel = 2'b00;
        if (hit1_mem)
        begin
            fwd1_sel = 2'b01;
        end
        else if (hit1_wb)
        begin
            fwd1_sel = 2'b10;
        end
        if (hit2_mem)
        begin
            fwd2_sel = 2'b01;
        end
        else if (hit2_wb)
        begin
            fwd2_sel = 2'b10;
        end
    end

    // load data only exists a cycle later, in writeback
    assign load_stall = mem_read_mem && (hit1_mem || hit2_mem);

endmodule : hazard_unit

/* src/execute_stage.sv */
module execute_stage
    import lc3b_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       stall,
    input  logic       load_stall,
    input  logic       flush,
    input  lc3b_word   a_ex,
    input  lc3b_word   b_ex,
    input  lc3b_word   imm_ex,
    input  lc3b_aluop  aluop_ex,
    input  lc3b_opcode opcode_ex,
    input  lc3b_reg    dest_ex,
    input  logic       load_reg_ex,
    input  logic       mem_read_ex,
    input  logic       mem_write_ex,
    input  logic       byte_ex,
    input  lc3b_nzp    nzp_ex,
    input  lc3b_word   target_ex,
    input  logic [1:0] fwd1_sel,
    input  logic [1:0] fwd2_sel,
    input  lc3b_word   fwd_mem,
    input  lc3b_word   fwd_wb,
    output lc3b_word   alu_mem,
    output lc3b_word   store_mem,
    output lc3b_reg    dest_mem,
    output logic       load_reg_mem,
    output logic       mem_read_mem,
    output logic       mem_write_mem,
    output logic       byte_mem,
    output logic       br_mem,
    output lc3b_nzp    nzp_mem,
    output lc3b_word   target_mem
);

    lc3b_word op_a;
    lc3b_word fwd_b;
    lc3b_word op_b;
    lc3b_word alu_out;
    logic     is_mem;

    assign op_a = (fwd1_sel == 2'b01) ? fwd_mem : (fwd1_sel == 2'b10) ? fwd_wb : a_ex;
    assign fwd_b = (fwd2_sel == 2'b01) ? fwd_mem : (fwd2_sel == 2'b10) ? fwd_wb : b_ex;

    // memory ops add base and offset, ALU ops take imm5 when flagged
    assign is_mem = mem_read_ex | mem_write_ex;
    assign op_b   = (is_mem || byte_ex) ? imm_ex : fwd_b;

    always_comb
    begin
        case (aluop_ex)
            alu_add: alu_out = op_a + op_b;
            alu_and: alu_out = op_a & op_b;
            alu_not: alu_out = ~op_a;
            default: alu_out = op_a;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst || (!stall && (flush || load_stall)))
        begin
            load_reg_mem  <= 1'b0;
            mem_read_mem  <= 1'b0;
            mem_write_mem <= 1'b0;
            byte_mem      <= 1'b0;
            br_mem        <= 1'b0;
        end
        else if (!stall)
        begin
            load_reg_mem  <= load_reg_ex;
            mem_read_mem  <= mem_read_ex;
            mem_write_mem <= mem_write_ex;
            byte_mem      <= byte_ex & is_mem;
            br_mem        <= (opcode_ex == op_br);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            alu_mem    <= alu_out;
            store_mem  <= fwd_b;
            dest_mem   <= dest_ex;
            nzp_mem    <= nzp_ex;
            target_mem <= target_ex;
        end
    end

endmodule : execute_stage

/* src/mem_wb_stage.sv */
module mem_wb_stage
    import lc3b_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          stall,
    input  lc3b_word      alu_mem,
    input  lc3b_word      store_mem,
    input  lc3b_reg       dest_mem,
    input  logic          load_reg_mem,
    input  logic          mem_read_mem,
    input  logic          mem_write_mem,
    input  logic          byte_mem,
    input  logic          br_mem,
    input  lc3b_nzp       nzp_mem,
    input  lc3b_word      target_mem,
    output logic          dmem_read,
    output logic          dmem_write,
    output lc3b_word      dmem_address,
    output lc3b_word      dmem_wdata,
    output lc3b_mem_wmask dmem_byte_enable,
    input  logic          dmem_resp,
    input  lc3b_word      dmem_rdata,
    output logic          mem_busy,
    output logic          flush,
    output lc3b_word      branch_target,
    output logic          wb_load,
    output lc3b_reg       wb_dest,
    output lc3b_word      wb_data,
    output lc3b_word      fwd_mem
);

    lc3b_word load_data;
    lc3b_word rdata;
    lc3b_word rdata_buf;
    logic     mem_done;
    lc3b_nzp  cc;
    lc3b_nzp  nzp_wb;
    lc3b_nzp  gen_cc;
    logic     br_wb;

    // a taken branch in writeback cancels the access behind it
    // an access already answered while frozen is not issued again
    assign dmem_read    = mem_read_mem & ~flush & ~mem_done;
    assign dmem_write   = mem_write_mem & ~flush & ~mem_done;
    assign dmem_address = alu_mem;
    assign dmem_wdata   = byte_mem ? {store_mem[7:0], store_mem[7:0]} : store_mem;
    assign dmem_byte_enable = byte_mem ? (alu_mem[0] ? 2'b10 : 2'b01) : 2'b11;
    assign mem_busy     = (dmem_read | dmem_write) & ~dmem_resp;
    assign fwd_mem      = alu_mem;

    // read data parked until the pipeline moves on
    assign rdata = mem_done ? rdata_buf : dmem_rdata;

    // byte loads zero-extend the addressed lane
    assign load_data = !byte_mem ? rdata :
                       alu_mem[0] ? {8'h00, rdata[15:8]} : {8'h00, rdata[7:0]};

    always_ff @(posedge clk)
    begin
        if (rst || !stall)
        begin
            mem_done <= 1'b0;
        end
        else if (dmem_resp)
        begin
            mem_done <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (dmem_resp)
        begin
            rdata_buf <= dmem_rdata;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst || (!stall && flush))
        begin
            wb_load <= 1'b0;
            br_wb   <= 1'b0;
        end
        else if (!stall)
        begin
            wb_load <= load_reg_mem;
            br_wb   <= br_mem;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            wb_dest       <= dest_mem;
            wb_data       <= mem_read_mem ? load_data : alu_mem;
            nzp_wb        <= nzp_mem;
            branch_target <= target_mem;
        end
    end

    assign gen_cc = wb_data[15] ? 3'b100 : (wb_data == '0) ? 3'b010 : 3'b001;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cc <= '0;
        end
        else if (!stall && wb_load)
        begin
            cc <= gen_cc;
        end
    end

    assign flush = br_wb & |(nzp_wb & cc);

endmodule : mem_wb_stage

/* src/lc3b_pipeline.sv */
module lc3b_pipeline
    import lc3b_pkg::*;
#(
    parameter lc3b_word RESET_PC = 16'h0000
)
(
    input  logic          clk,
    input  logic          rst,
    output logic          imem_read,
    output lc3b_word      imem_address,
    input  logic          imem_resp,
    input  lc3b_word      imem_rdata,
    output logic          dmem_read,
    output logic          dmem_write,
    output lc3b_word      dmem_address,
    output lc3b_word      dmem_wdata,
    output lc3b_mem_wmask dmem_byte_enable,
    input  logic          dmem_resp,
    input  lc3b_word      dmem_rdata
);

    logic stall, load_stall, flush, fetch_busy, mem_busy;
    lc3b_word branch_target, ir_id, pc_id;
    logic wb_load;
    lc3b_reg wb_dest;
    lc3b_word wb_data, fwd_mem;
    lc3b_reg sr1_ex, sr2_ex, dest_ex;
    lc3b_word a_ex, b_ex, imm_ex, target_ex;
    lc3b_aluop aluop_ex;
    lc3b_opcode opcode_ex;
    logic load_reg_ex, mem_read_ex, mem_write_ex, byte_ex;
    lc3b_nzp nzp_ex, nzp_mem;
    logic [1:0] fwd1_sel, fwd2_sel;
    lc3b_word alu_mem, store_mem, target_mem;
    lc3b_reg dest_mem;
    logic load_reg_mem, mem_read_mem, mem_write_mem, byte_mem, br_mem;

    // either memory waiting freezes every stage
    assign stall = fetch_busy | mem_busy;

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch_stage
    (
        .clk, .rst, .stall, .load_stall, .flush, .branch_target,
        .imem_read, .imem_address, .imem_resp, .imem_rdata,
        .fetch_busy, .ir_id, .pc_id
    );

    decode_stage u_decode_stage
    (
        .clk, .rst, .stall, .load_stall, .flush, .ir_id, .pc_id,
        .wb_load, .wb_dest, .wb_data,
        .sr1_ex, .sr2_ex, .a_ex, .b_ex, .imm_ex, .aluop_ex, .opcode_ex, .dest_ex,
        .load_reg_ex, .mem_read_ex, .mem_write_ex, .byte_ex, .nzp_ex, .target_ex
    );

    hazard_unit u_hazard_unit
    (
        .sr1_ex, .sr2_ex, .dest_mem, .dest_wb(wb_dest),
        .load_reg_mem, .load_reg_wb(wb_load), .mem_read_mem,
        .fwd1_sel, .fwd2_sel, .load_stall
    );

    execute_stage u_execute_stage
    (
        .clk, .rst, .stall, .load_stall, .flush,
        .a_ex, .b_ex, .imm_ex, .aluop_ex, .opcode_ex, .dest_ex,
        .load_reg_ex, .mem_read_ex, .mem_write_ex, .byte_ex, .nzp_ex, .target_ex,
        .fwd1_sel, .fwd2_sel, .fwd_mem, .fwd_wb(wb_data),
        .alu_mem, .store_mem, .dest_mem, .load_reg_mem, .mem_read_mem,
        .mem_write_mem, .byte_mem, .br_mem, .nzp_mem, .target_mem
    );

    mem_wb_stage u_mem_wb_stage
    (
        .clk, .rst, .stall,
        .alu_mem, .store_mem, .dest_mem, .load_reg_mem, .mem_read_mem,
        .mem_write_mem, .byte_mem, .br_mem, .nzp_mem, .target_mem,
        .dmem_read, .dmem_write, .dmem_address, .dmem_wdata, .dmem_byte_enable,
        .dmem_resp, .dmem_rdata,
        .mem_busy, .flush, .branch_target, .wb_load, .wb_dest, .wb_data, .fwd_mem
    );

endmodule : lc3b_pipeline

/* verification/tb_mem_model.sv */
module tb_mem_model
(
    input  logic        clk,
    input  logic        rst,
    input  logic        imem_read,
    input  logic [15:0] imem_address,
    output logic        imem_resp,
    output logic [15:0] imem_rdata,
    input  logic        dmem_read,
    input  logic        dmem_write,
    input  logic [15:0] dmem_address,
    input  logic [15:0] dmem_wdata,
    input  logic [1:0]  dmem_byte_enable,
    output logic        dmem_resp,
    output logic [15:0] dmem_rdata
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [15:0] rom [256];
    logic [15:0] ram [256];
    logic [31:0] lfsr;
    logic        i_active;
    logic        d_active;
    logic [1:0]  i_wait;
    logic [1:0]  d_wait;

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // two bits, one step each
    task automatic pick_latency(output logic [1:0] lat);
        lat[0] = lfsr[0];
        lfsr = lfsr_next(lfsr);
        lat[1] = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    initial
    begin
        lfsr = 32'hb928e7fc;
        for (int i = 0; i < 256; i++)
        begin
            rom[i] = '0;
            ram[i] = (16'(i) * 16'h9e37) ^ 16'h5a3c;
        end
        imem_resp  = 1'b0;
        imem_rdata = '0;
        dmem_resp  = 1'b0;
        dmem_rdata = '0;
        i_active   = 1'b0;
        d_active   = 1'b0;
        i_wait     = '0;
        d_wait     = '0;
    end

    always @(negedge clk)
    begin
        imem_resp = 1'b0;
        dmem_resp = 1'b0;
        if (rst)
        begin
            i_active = 1'b0;
            d_active = 1'b0;
        end
        else
        begin
            if (!imem_read)
            begin
                i_active = 1'b0;
            end
            else
            begin
                if (!i_active)
                begin
                    i_active = 1'b1;
                    pick_latency(i_wait);
                end
                if (i_wait == 2'd0)
                begin
                    imem_resp  = 1'b1;
                    imem_rdata = rom[imem_address[8:1]];
                    i_active   = 1'b0;
                end
                else
                begin
                    i_wait = i_wait - 2'd1;
                end
            end
            if (!(dmem_read || dmem_write))
            begin
                d_active = 1'b0;
            end
            else
            begin
                if (!d_active)
                begin
                    d_active = 1'b1;
                    pick_latency(d_wait);
                end
                if (d_wait == 2'd0)
                begin
                    dmem_resp  = 1'b1;
                    dmem_rdata = ram[dmem_address[8:1]];
                    d_active   = 1'b0;
                    // write lands when the response is given
                    if (dmem_write && dmem_byte_enable[0])
                    begin
                        ram[dmem_address[8:1]][7:0] = dmem_wdata[7:0];
                    end
                    if (dmem_write && dmem_byte_enable[1])
                    begin
                        ram[dmem_address[8:1]][15:8] = dmem_wdata[15:8];
                    end
                end
                else
                begin
                    d_wait = d_wait - 2'd1;
                end
            end
        end
    end

endmodule : tb_mem_model

/* verification/tb_lc3b.sv */
module tb_lc3b;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [15:0] RESET_PC = 16'h0040;
    localparam int          TIMEOUT  = 3000;

    logic        clk;
    logic        rst;
    logic        imem_read;
    logic [15:0] imem_address;
    logic        imem_resp;
    logic [15:0] imem_rdata;
    logic        dmem_read;
    logic        dmem_write;
    logic [15:0] dmem_address;
    logic [15:0] dmem_wdata;
    logic [1:0]  dmem_byte_enable;
    logic        dmem_resp;
    logic [15:0] dmem_rdata;

    logic [15:0] prog [$];
    logic [15:0] exp_addr [$];
    logic [15:0] exp_data [$];
    logic [1:0]  exp_mask [$];
    logic [15:0] lanes;
    int          errors;
    int          tests;
    int          passed;
    int          checks;
    logic [15:0] r1;
    logic [15:0] r2;
    logic [15:0] r3;

    lc3b_pipeline #(.RESET_PC(RESET_PC)) u_lc3b_pipeline
    (
        .clk, .rst, .imem_read, .imem_address, .imem_resp, .imem_rdata,
        .dmem_read, .dmem_write, .dmem_address, .dmem_wdata, .dmem_byte_enable,
        .dmem_resp, .dmem_rdata
    );

    tb_mem_model u_mem_model
    (
        .clk, .rst, .imem_read, .imem_address, .imem_resp, .imem_rdata,
        .dmem_read, .dmem_write, .dmem_address, .dmem_wdata, .dmem_byte_enable,
        .dmem_resp, .dmem_rdata
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // instruction encoders
    function automatic logic [15:0] add_reg(input int d, input int a, input int b);
        return {4'b0001, 3'(d), 3'(a), 3'b000, 3'(b)};
    endfunction
    function automatic logic [15:0] add_imm(input int d, input int a, input int imm);
        return {4'b0001, 3'(d), 3'(a), 1'b1, 5'(imm)};
    endfunction
    function automatic logic [15:0] and_reg(input int d, input int a, input int b);
        return {4'b0101, 3'(d), 3'(a), 3'b000, 3'(b)};
    endfunction
    function automatic logic [15:0] and_imm(input int d, input int a, input int imm);
        return {4'b0101, 3'(d), 3'(a), 1'b1, 5'(imm)};
    endfunction
    function automatic logic [15:0] not_reg(input int d, input int a);
        return {4'b1001, 3'(d), 3'(a), 6'b111111};
    endfunction
    function automatic logic [15:0] mem_op(input logic [3:0] op, input int r, input int b,
                                           input int off);
        return {op, 3'(r), 3'(b), 6'(off)};
    endfunction
    function automatic logic [15:0] branch(input logic [2:0] nzp, input int off);
        return {4'b0000, nzp, 9'(off)};
    endfunction
    function automatic logic [15:0] sext5(input int v);
        return {{11{5'(v) >> 4 != 0}}, 5'(v)};
    endfunction

    task automatic expect_store(input logic [15:0] a, input logic [15:0] d,
                                input logic [1:0] m);
        exp_addr.push_back(a);
        exp_data.push_back(d);
        exp_mask.push_back(m);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst <= 1'b1;
        for (int i = 0; i < 256; i++)
        begin
            u_mem_model.rom[i] = '0;
        end
        foreach (prog[i])
        begin
            u_mem_model.rom[8'(RESET_PC[8:1] + i)] = prog[i];
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        assert (!dmem_read)
        else
        begin
            $display("MISMATCH dmem_read: got %h expected %h", dmem_read, 1'b0);
            errors++;
        end
        assert (!dmem_write)
        else
        begin
            $display("MISMATCH dmem_write: got %h expected %h", dmem_write, 1'b0);
            errors++;
        end
        assert (imem_read)
        else
        begin
            $display("MISMATCH imem_read: got %h expected %h", imem_read, 1'b1);
            errors++;
        end
        assert (imem_address == RESET_PC)
        else
        begin
            $display("MISMATCH imem_address: got %h expected %h", imem_address, RESET_PC);
            errors++;
        end
        rst <= 1'b0;
    endtask

    task automatic run_test(input string name);
        int err0;
        int cycles;
        err0 = errors;
        cycles = 0;
        // halt loop keeps the previous program away from memory
        prog.push_back(branch(3'b111, -1));
        apply_reset();
        while (exp_addr.size() != 0 && cycles < TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (exp_addr.size() != 0)
        begin
            $display("timeout in %s, %0d stores never appeared", name, exp_addr.size());
            errors++;
            exp_addr.delete();
            exp_data.delete();
            exp_mask.delete();
        end
        prog.delete();
        tests++;
        if (errors == err0)
        begin
            passed++;
            $display("%s: ok", name);
        end
        else
        begin
            $display("%s: FAILED with %0d errors", name, errors - err0);
        end
    endtask

    // every completed write is checked against the head of the list
    always @(posedge clk)
    begin
        if (!rst && dmem_write && dmem_resp)
        begin
            assert (exp_addr.size() != 0)
            else
            begin
                $display("unexpected store to address %h", dmem_address);
                errors++;
            end
            if (exp_addr.size() != 0)
            begin
                lanes = {{8{exp_mask[0][1]}}, {8{exp_mask[0][0]}}};
                assert (dmem_address == exp_addr[0])
                else
                begin
                    $display("MISMATCH dmem_address: got %h expected %h",
                             dmem_address, exp_addr[0]);
                    errors++;
                end
                assert (dmem_byte_enable == exp_mask[0])
                else
                begin
                    $display("MISMATCH dmem_byte_enable: got %h expected %h",
                             dmem_byte_enable, exp_mask[0]);
                    errors++;
                end
                assert ((dmem_wdata & lanes) == (exp_data[0] & lanes))
                else
                begin
                    $display("MISMATCH dmem_wdata: got %h expected %h",
                             dmem_wdata & lanes, exp_data[0] & lanes);
                    errors++;
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
                void'(exp_mask.pop_front());
                checks++;
            end
        end
    end

    always @(posedge clk)
    begin
        assert (rst || !(dmem_read && dmem_write))
        else
        begin
            $display("read and write requested together");
            errors++;
        end
    end

    initial
    begin
        rst = 1'b1;
        errors = 0;
        tests = 0;
        passed = 0;
        checks = 0;

        run_test("reset");

        // alu, register and immediate forms
        r1 = 16'd7;
        r2 = sext5(-3);
        prog = '{add_imm(1, 0, 7), add_imm(2, 0, -3), add_reg(3, 1, 2), and_imm(4, 2, -2),
                 and_reg(5, 1, 2), not_reg(6, 2), mem_op(4'b0111, 3, 0, 1),
                 mem_op(4'b0111, 4, 0, 2), mem_op(4'b0111, 5, 0, 3),
                 mem_op(4'b0111, 6, 0, 4), mem_op(4'b0111, 1, 0, 5)};
        expect_store(16'd2, r1 + r2, 2'b11);
        expect_store(16'd4, r2 & sext5(-2), 2'b11);
        expect_store(16'd6, r1 & r2, 2'b11);
        expect_store(16'd8, ~r2, 2'b11);
        expect_store(16'd10, r1, 2'b11);
        run_test("alu");

        // distance one and two chains
        prog = '{add_imm(1, 0, 3), add_imm(2, 1, 4), add_reg(3, 2, 1), add_reg(4, 3, 1),
                 mem_op(4'b0111, 4, 0, 3), mem_op(4'b0111, 2, 0, 1),
                 mem_op(4'b0111, 3, 0, 2)};
        expect_store(16'd6, 16'd13, 2'b11);
        expect_store(16'd2, 16'd7, 2'b11);
        expect_store(16'd4, 16'd10, 2'b11);
        run_test("forwarding");

        r1 = sext5(-7);
        prog = '{add_imm(1, 0, -7), mem_op(4'b0111, 1, 0, 8), mem_op(4'b0110, 2, 0, 8),
                 add_imm(3, 2, 5), mem_op(4'b0111, 3, 0, 9)};
        expect_store(16'd16, r1, 2'b11);
        expect_store(16'd18, r1 + 16'd5, 2'b11);
        run_test("load_use");

        // odd byte address uses the high lane only
        r1 = sext5(-6);
        prog = '{add_imm(1, 0, -6), mem_op(4'b0011, 1, 0, 21), mem_op(4'b0010, 2, 0, 21),
                 mem_op(4'b0111, 2, 0, 12)};
        expect_store(16'd21, {r1[7:0], 8'h00}, 2'b10);
        expect_store(16'd24, {8'h00, r1[7:0]}, 2'b11);
        run_test("byte");

        r3 = 16'd12;
        prog = '{add_imm(5, 0, 12), and_imm(1, 0, 0), branch(3'b010, 3),
                 mem_op(4'b0111, 5, 0, 16), mem_op(4'b0111, 5, 0, 17),
                 mem_op(4'b0111, 5, 0, 18), branch(3'b100, 1), mem_op(4'b0111, 5, 0, 20)};
        expect_store(16'd40, r3, 2'b11);
        run_test("branch");

        $display("tests %0d, passed %0d, failed %0d, stores checked %0d, errors %0d",
                 tests, passed, tests - passed, checks, errors);
        if (errors == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule : tb_lc3b

/* all.f */
src/lc3b_pkg.sv
src/fetch_stage.sv
src/regfile.sv
src/decode_stage.sv
src/hazard_unit.sv
src/execute_stage.sv
src/mem_wb_stage.sv
src/lc3b_pipeline.sv
verification/tb_mem_model.sv
verification/tb_lc3b.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_lc3b
FLIST     ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
